// File: hdl/axi_chan_pkg.sv
// AXI4 and AXI-Lite channel definitions for a single-ID, single-beat subsystem
// USER signals, atomics and exclusive access are not carried
`default_nettype none

package axi_chan_pkg;

  // Bus geometry
  localparam int unsigned addr_width = 32;
  localparam int unsigned data_width = 32;
  localparam int unsigned strb_width = data_width / 8;
  localparam int unsigned id_width   = 4;

  // SRAM depth in words, the slave wraps addresses beyond it
  localparam int unsigned mem_words  = 256;

  // Response codes, EXOKAY and DECERR are never produced here
  typedef logic [1:0] resp_t;
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // Fixed AXI4 attributes of a single-beat burst
  localparam logic [1:0] burst_incr = 2'b01;
  // Size code covering the whole data bus, log2 of the byte count
  localparam logic [2:0] size_full  = 3'($clog2(strb_width));

  // AXI-Lite channels
  typedef struct packed {
    logic [addr_width-1:0] addr;
  } lite_aw_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
  } lite_w_t;

  typedef struct packed {
    resp_t resp;
  } lite_b_t;

  typedef struct packed {
    logic [addr_width-1:0] addr;
  } lite_ar_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    resp_t                 resp;
  } lite_r_t;

  // AXI4 channels, the address beat serves both AW and AR
  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
    logic [3:0]            cache;
    // Same bit order as the protection field in the config package
    logic [2:0]            prot;
  } axi_ax_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [id_width-1:0] id;
    resp_t               resp;
  } axi_b_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    resp_t                 resp;
    logic                  last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: hdl/bridge_cfg_pkg.sv
// Register map of the bridge configuration block
// Only two registers exist, selected by a single address bit
`default_nettype none

package bridge_cfg_pkg;

  // AXI protection field, bit 0 privileged, bit 1 non-secure, bit 2 instruction
  typedef struct packed {
    logic instr;
    logic nonsecure;
    logic privileged;
  } prot_t;

  // Register select
  typedef logic [0:0] cfg_addr_t;
  localparam cfg_addr_t cfg_reg_aw_prot = 1'b0;
  localparam cfg_addr_t cfg_reg_ar_prot = 1'b1;

  // Unprivileged, secure, data access
  localparam prot_t prot_reset = '{instr: 1'b0, nonsecure: 1'b0, privileged: 1'b0};

  // Attributes handed to the bridge for every request it forms
  typedef struct packed {
    prot_t aw_prot;
    prot_t ar_prot;
  } cfg_bundle_t;

endpackage

`default_nettype wire

// File: hdl/spill_reg.sv
// Two-entry valid/ready buffer with registered data and ready paths
// Input ready stays low for the first cycle after reset
`default_nettype none

module spill_reg #(
  parameter type payload_t = logic
) (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire logic     in_valid,
  output logic          in_ready,
  input  wire payload_t in_data,
  output logic          out_valid,
  input  wire logic     out_ready,
  output payload_t      out_data
);

  // Slot a faces the output, slot b catches the beat that arrives while a is stalled
  payload_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q, a_full_d, b_full_d;
  logic     a_load_in, a_load_b, b_load;
  logic     in_fire, out_fire;

  assign in_fire   = in_valid && in_ready;
  assign out_fire  = a_full_q && out_ready;
  assign out_valid = a_full_q;
  assign out_data  = a_data_q;

  always_comb begin
    a_full_d  = a_full_q;
    b_full_d  = b_full_q;
    a_load_in = 1'b0;
    a_load_b  = 1'b0;
    b_load    = 1'b0;
    if (out_fire) begin
      // While b holds a beat, in_ready is low, so no new beat competes here
      if (b_full_q) begin
        a_load_b = 1'b1;
        b_full_d = 1'b0;
      end else if (in_fire) begin
        a_load_in = 1'b1;
      end else begin
        a_full_d = 1'b0;
      end
    end else if (in_fire) begin
      if (!a_full_q) begin
        a_load_in = 1'b1;
        a_full_d  = 1'b1;
      end else begin
        b_load   = 1'b1;
        b_full_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      in_ready <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      // Ready is taken from the next state so it never lags the slot count
      in_ready <= !b_full_d;
    end
  end

  always_ff @(posedge clk) begin
    if (a_load_in) a_data_q <= in_data;
    else if (a_load_b) a_data_q <= b_data_q;
    if (b_load) b_data_q <= in_data;
  end

endmodule

`default_nettype wire

// File: hdl/bridge_cfg_regs.sv
// Protection attribute registers for the bridge with a plain strobe write port
// Readback is combinational on the current select
`default_nettype none

module bridge_cfg_regs import bridge_cfg_pkg::*; (
  input  wire logic      clk,
  input  wire logic      arst_n,
  input  wire logic      cfg_we,
  input  wire cfg_addr_t cfg_addr,
  input  wire prot_t     cfg_wdata,
  output prot_t          cfg_rdata,
  output cfg_bundle_t    cfg
);

  prot_t aw_prot_q;
  prot_t ar_prot_q;
  logic  aw_sel, ar_sel;

  // Each register owns one select value
  assign aw_sel = (cfg_addr == cfg_reg_aw_prot);
  assign ar_sel = (cfg_addr == cfg_reg_ar_prot);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      aw_prot_q <= prot_reset;
      ar_prot_q <= prot_reset;
    end else if (cfg_we) begin
      // A write is visible to the bridge from the next cycle on
      if (aw_sel) aw_prot_q <= cfg_wdata;
      if (ar_sel) ar_prot_q <= cfg_wdata;
    end
  end

  // The single select bit always picks one of the two registers
  always_comb begin
    if (aw_sel) begin
      cfg_rdata = aw_prot_q;
    end else begin
      cfg_rdata = ar_prot_q;
    end
  end

  // Attributes seen by the bridge
  assign cfg.aw_prot = aw_prot_q;
  assign cfg.ar_prot = ar_prot_q;

endmodule

`default_nettype wire

// File: hdl/axi_lite_to_axi.sv
// AXI-Lite to AXI4 converter issuing one single-beat INCR burst per transaction
// ID and cache are fixed at 0, protection comes from the configuration block
`default_nettype none

module axi_lite_to_axi import axi_chan_pkg::*, bridge_cfg_pkg::*; (
  input  wire logic        clk,
  input  wire logic        arst_n,
  // Lite slave side
  input  wire lite_aw_t    lite_aw,
  input  wire logic        lite_aw_valid,
  output logic             lite_aw_ready,
  input  wire lite_w_t     lite_w,
  input  wire logic        lite_w_valid,
  output logic             lite_w_ready,
  output lite_b_t          lite_b,
  output logic             lite_b_valid,
  input  wire logic        lite_b_ready,
  input  wire lite_ar_t    lite_ar,
  input  wire logic        lite_ar_valid,
  output logic             lite_ar_ready,
  output lite_r_t          lite_r,
  output logic             lite_r_valid,
  input  wire logic        lite_r_ready,
  input  wire cfg_bundle_t cfg,
  // AXI4 master side
  output axi_ax_t          axi_aw,
  output logic             axi_aw_valid,
  input  wire logic        axi_aw_ready,
  output axi_w_t           axi_w,
  output logic             axi_w_valid,
  input  wire logic        axi_w_ready,
  input  wire axi_b_t      axi_b,
  input  wire logic        axi_b_valid,
  output logic             axi_b_ready,
  output axi_ax_t          axi_ar,
  output logic             axi_ar_valid,
  input  wire logic        axi_ar_ready,
  input  wire axi_r_t      axi_r,
  input  wire logic        axi_r_valid,
  output logic             axi_r_ready
);

  axi_ax_t aw_beat, ar_beat;
  axi_w_t  w_beat;

  // Single-beat burst covering the full bus width
  always_comb begin
    aw_beat       = '0;
    aw_beat.addr  = lite_aw.addr;
    aw_beat.size  = size_full;
    aw_beat.burst = burst_incr;
    // Prot is sampled at the Lite handshake and travels with the beat
    aw_beat.prot  = cfg.aw_prot;

    ar_beat       = '0;
    ar_beat.addr  = lite_ar.addr;
    ar_beat.size  = size_full;
    ar_beat.burst = burst_incr;
    ar_beat.prot  = cfg.ar_prot;
  end

  // Every write is exactly one beat, so last is always set
  assign w_beat = '{data: lite_w.data, strb: lite_w.strb, last: 1'b1};

  // Request channels get a registered boundary
  spill_reg #(.payload_t(axi_ax_t)) u_aw_spill (
    .clk, .arst_n,
    .in_valid (lite_aw_valid), .in_ready (lite_aw_ready), .in_data (aw_beat),
    .out_valid(axi_aw_valid),  .out_ready(axi_aw_ready),  .out_data(axi_aw)
  );

  spill_reg #(.payload_t(axi_w_t)) u_w_spill (
    .clk, .arst_n,
    .in_valid (lite_w_valid), .in_ready (lite_w_ready), .in_data (w_beat),
    .out_valid(axi_w_valid),  .out_ready(axi_w_ready),  .out_data(axi_w)
  );

  spill_reg #(.payload_t(axi_ax_t)) u_ar_spill (
    .clk, .arst_n,
    .in_valid (lite_ar_valid), .in_ready (lite_ar_ready), .in_data (ar_beat),
    .out_valid(axi_ar_valid),  .out_ready(axi_ar_ready),  .out_data(axi_ar)
  );

  // Responses pass straight through, the ID is always 0 and R is single-beat
  assign lite_b.resp  = axi_b.resp;
  assign lite_b_valid = axi_b_valid;
  assign axi_b_ready  = lite_b_ready;

  assign lite_r.data  = axi_r.data;
  assign lite_r.resp  = axi_r.resp;
  assign lite_r_valid = axi_r_valid;
  assign axi_r_ready  = lite_r_ready;

endmodule

`default_nettype wire

// File: hdl/axi_sram_slave.sv
// Single-outstanding AXI4 SRAM slave, one write and one read in flight at most
// Bursts are not supported, len is ignored and every access is one word
`default_nettype none

module axi_sram_slave import axi_chan_pkg::*, bridge_cfg_pkg::*; (
  input  wire logic    clk,
  input  wire logic    arst_n,
  input  wire axi_ax_t aw,
  input  wire logic    aw_valid,
  output logic         aw_ready,
  input  wire axi_w_t  w,
  input  wire logic    w_valid,
  output logic         w_ready,
  output axi_b_t       b,
  output logic         b_valid,
  input  wire logic    b_ready,
  input  wire axi_ax_t ar,
  input  wire logic    ar_valid,
  output logic         ar_ready,
  output axi_r_t       r,
  output logic         r_valid,
  input  wire logic    r_ready
);

  // Word index sits above the byte offset, higher address bits wrap
  localparam int unsigned off_width = $clog2(strb_width);
  localparam int unsigned idx_width = $clog2(mem_words);
  // Top index bit marks the protected upper half
  localparam int unsigned prot_bit  = off_width + idx_width - 1;

  logic [data_width-1:0] mem [mem_words];

  logic [idx_width-1:0] aw_idx, ar_idx;
  prot_t                aw_prot, ar_prot;
  logic                 aw_allowed, ar_allowed;
  logic                 wr_fire, rd_fire;

  assign aw_idx  = aw.addr[prot_bit:off_width];
  assign ar_idx  = ar.addr[prot_bit:off_width];
  assign aw_prot = prot_t'(aw.prot);
  assign ar_prot = prot_t'(ar.prot);

  // Upper half needs a privileged access, the lower half is open to all
  assign aw_allowed = aw_prot.privileged || !aw.addr[prot_bit];
  assign ar_allowed = ar_prot.privileged || !ar.addr[prot_bit];

  // AW and W are taken together, and only once the previous B has left
  assign aw_ready = aw_valid && w_valid && !b_valid;
  assign w_ready  = aw_ready;
  assign wr_fire  = aw_ready;

  assign ar_ready = !r_valid;
  assign rd_fire  = ar_valid && ar_ready;

  // Byte-strobe write, a refused write leaves the word untouched
  always_ff @(posedge clk) begin
    if (wr_fire && aw_allowed) begin
      for (int i = 0; i < strb_width; i++) begin
        if (w.strb[i]) mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

  // Response handshake state
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
    end else begin
      if (wr_fire) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
      if (rd_fire) begin
        r_valid <= 1'b1;
      end else if (r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Response payloads are captured at the request and held until accepted
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      b.id   <= aw.id;
      b.resp <= aw_allowed ? resp_okay : resp_slverr;
    end
    if (rd_fire) begin
      r.id   <= ar.id;
      // Refused reads return zero so protected contents never leak
      r.data <= ar_allowed ? mem[ar_idx] : '0;
      r.resp <= ar_allowed ? resp_okay : resp_slverr;
      r.last <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/lite_bridge_top.sv
// Lite bridge subsystem, configuration registers, converter and SRAM slave
// The AXI4 side is internal, only the Lite port and config strobes are exposed
`default_nettype none

module lite_bridge_top import axi_chan_pkg::*, bridge_cfg_pkg::*; (
  input  wire logic      clk,
  input  wire logic      arst_n,
  // Configuration port
  input  wire logic      cfg_we,
  input  wire cfg_addr_t cfg_addr,
  input  wire prot_t     cfg_wdata,
  output prot_t          cfg_rdata,
  // Lite slave port
  input  wire lite_aw_t  lite_aw,
  input  wire logic      lite_aw_valid,
  output logic           lite_aw_ready,
  input  wire lite_w_t   lite_w,
  input  wire logic      lite_w_valid,
  output logic           lite_w_ready,
  output lite_b_t        lite_b,
  output logic           lite_b_valid,
  input  wire logic      lite_b_ready,
  input  wire lite_ar_t  lite_ar,
  input  wire logic      lite_ar_valid,
  output logic           lite_ar_ready,
  output lite_r_t        lite_r,
  output logic           lite_r_valid,
  input  wire logic      lite_r_ready
);

  cfg_bundle_t cfg;

  // Internal AXI4 link between the converter and the SRAM
  axi_ax_t aw, ar;
  axi_w_t  w;
  axi_b_t  b;
  axi_r_t  r;
  logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic    ar_valid, ar_ready, r_valid, r_ready;

  bridge_cfg_regs u_cfg_regs (
    .clk, .arst_n, .cfg_we, .cfg_addr, .cfg_wdata, .cfg_rdata, .cfg
  );

  axi_lite_to_axi u_bridge (
    .clk, .arst_n,
    .lite_aw, .lite_aw_valid, .lite_aw_ready,
    .lite_w,  .lite_w_valid,  .lite_w_ready,
    .lite_b,  .lite_b_valid,  .lite_b_ready,
    .lite_ar, .lite_ar_valid, .lite_ar_ready,
    .lite_r,  .lite_r_valid,  .lite_r_ready,
    .cfg,
    .axi_aw(aw), .axi_aw_valid(aw_valid), .axi_aw_ready(aw_ready),
    .axi_w (w),  .axi_w_valid (w_valid),  .axi_w_ready (w_ready),
    .axi_b (b),  .axi_b_valid (b_valid),  .axi_b_ready (b_ready),
    .axi_ar(ar), .axi_ar_valid(ar_valid), .axi_ar_ready(ar_ready),
    .axi_r (r),  .axi_r_valid (r_valid),  .axi_r_ready (r_ready)
  );

  axi_sram_slave u_sram (
    .clk, .arst_n,
    .aw, .aw_valid, .aw_ready,
    .w,  .w_valid,  .w_ready,
    .b,  .b_valid,  .b_ready,
    .ar, .ar_valid, .ar_ready,
    .r,  .r_valid,  .r_ready
  );

endmodule

`default_nettype wire

// File: bench/tb_lite_bridge.sv
// Table-driven testbench for the Lite bridge, one transaction in flight at a time
// Every read address must have been fully written first, the SRAM is not initialized
`default_nettype none

module tb_lite_bridge import axi_chan_pkg::*, bridge_cfg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned idx_w = $clog2(mem_words);
  typedef logic [idx_w-1:0] idx_t;
  typedef enum logic [1:0] {op_cfg, op_write, op_read} op_t;

  // One row of the stimulus table, for op_cfg the addr selects the register
  typedef struct packed {
    op_t                   kind;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    prot_t                 prot;
    resp_t                 exp;
    logic                  stall;
  } entry_t;

  logic clk, arst_n, cfg_we;
  cfg_addr_t cfg_addr;
  prot_t cfg_wdata, cfg_rdata;
  lite_aw_t lite_aw;
  lite_w_t lite_w;
  lite_b_t lite_b;
  lite_ar_t lite_ar;
  lite_r_t lite_r;
  logic lite_aw_valid, lite_aw_ready, lite_w_valid, lite_w_ready;
  logic lite_b_valid, lite_b_ready, lite_ar_valid, lite_ar_ready;
  logic lite_r_valid, lite_r_ready;

  entry_t tests [$];
  logic [data_width-1:0] model [mem_words];
  prot_t aw_prot_now, ar_prot_now;
  integer seed = 94;
  int errors = 0;
  int checks = 0;
  int writes_sent = 0;
  int reads_sent = 0;
  int b_seen = 0;
  int r_seen = 0;
  int unsigned cycles = 0;
  int unsigned limit = 0;

  lite_bridge_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Count every response handshake so lost or repeated beats show up at the end
  always @(posedge clk) begin
    if (lite_b_valid && lite_b_ready) b_seen++;
    if (lite_r_valid && lite_r_ready) r_seen++;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: the table did not finish within %0d cycles", limit);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  // Word index after wrapping, independent of how the slave slices the address
  function automatic idx_t word_index(input logic [addr_width-1:0] addr);
    return idx_t'((addr / strb_width) % mem_words);
  endfunction

  // The upper half of the SRAM is open only to privileged accesses
  function automatic logic access_allowed(input logic [addr_width-1:0] addr, input prot_t prot);
    return prot.privileged || (word_index(addr) < idx_t'(mem_words / 2));
  endfunction

  function automatic logic [data_width-1:0] merge_strb(input logic [data_width-1:0] old,
      input logic [data_width-1:0] wdata, input logic [strb_width-1:0] strb);
    logic [data_width-1:0] res;
    res = old;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) res[8*i +: 8] = wdata[8*i +: 8];
    end
    return res;
  endfunction

  task automatic check_resp(input string what, input resp_t got, input resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s response %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_data(input string what, input logic [data_width-1:0] got,
      input logic [data_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_prot(input string what, input prot_t got, input prot_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s %03b, expected %03b", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input op_t kind, input logic [addr_width-1:0] addr,
      input logic [data_width-1:0] data, input logic [strb_width-1:0] strb,
      input prot_t prot, input resp_t exp, input logic stall);
    tests.push_back('{kind, addr, data, strb, prot, exp, stall});
  endtask

  // All drivers start and end 1 ns after a rising edge
  task automatic write_cfg(input cfg_addr_t sel, input prot_t value);
    cfg_we = 1'b1;
    cfg_addr = sel;
    cfg_wdata = value;
    @(posedge clk);
    #1;
    cfg_we = 1'b0;
    check_prot($sformatf("config register %0d readback", sel), cfg_rdata, value);
    if (sel == cfg_reg_aw_prot) aw_prot_now = value;
    else ar_prot_now = value;
  endtask

  // Random response back-pressure, drawn from the seeded generator
  task automatic stall_cycles();
    int unsigned hold;
    hold = 2 + ({$random(seed)} % 8);
    repeat (hold) @(posedge clk);
    #1;
  endtask

  task automatic lite_write_txn(input logic [addr_width-1:0] addr,
      input logic [data_width-1:0] data, input logic [strb_width-1:0] strb,
      input logic stall, output resp_t resp);
    logic aw_done, w_done;
    aw_done = 1'b0;
    w_done = 1'b0;
    lite_aw.addr = addr;
    lite_w.data = data;
    lite_w.strb = strb;
    lite_aw_valid = 1'b1;
    lite_w_valid = 1'b1;
    lite_b_ready = !stall;
    // AW and W may complete in different cycles, each drops on its own
    while (!(aw_done && w_done)) begin
      @(posedge clk);
      if (lite_aw_valid && lite_aw_ready) aw_done = 1'b1;
      if (lite_w_valid && lite_w_ready) w_done = 1'b1;
      #1;
      if (aw_done) lite_aw_valid = 1'b0;
      if (w_done) lite_w_valid = 1'b0;
    end
    if (stall) begin
      stall_cycles();
      lite_b_ready = 1'b1;
    end
    @(posedge clk);
    while (!(lite_b_valid && lite_b_ready)) @(posedge clk);
    resp = lite_b.resp;
    #1;
    lite_b_ready = 1'b0;
  endtask

  task automatic lite_read_txn(input logic [addr_width-1:0] addr, input logic stall,
      output logic [data_width-1:0] data, output resp_t resp);
    lite_ar.addr = addr;
    lite_ar_valid = 1'b1;
    lite_r_ready = !stall;
    @(posedge clk);
    while (!lite_ar_ready) @(posedge clk);
    #1;
    lite_ar_valid = 1'b0;
    if (stall) begin
      stall_cycles();
      lite_r_ready = 1'b1;
    end
    @(posedge clk);
    while (!(lite_r_valid && lite_r_ready)) @(posedge clk);
    data = lite_r.data;
    resp = lite_r.resp;
    #1;
    lite_r_ready = 1'b0;
  endtask

  initial begin
    entry_t e;
    resp_t resp;
    logic [data_width-1:0] rdata;
    // Readback of arbitrary values, then back to unprivileged
    add_entry(op_cfg, 32'h0, '0, 4'h0, 3'b011, resp_okay, 1'b0);
    add_entry(op_cfg, 32'h1, '0, 4'h0, 3'b110, resp_okay, 1'b0);
    add_entry(op_cfg, 32'h0, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_cfg, 32'h1, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    // Lower half, open to unprivileged accesses, with byte-strobe merges
    add_entry(op_write, 32'h0000_0010, 32'hA5A5_1234, 4'hF, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_0010, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_0010, 32'hCAFE_0000, 4'hC, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_0010, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    add_entry(op_write, 32'h0000_0044, 32'h0123_4567, 4'hF, prot_reset, resp_okay, 1'b1);
    add_entry(op_write, 32'h0000_0044, 32'h00AB_00CD, 4'h5, prot_reset, resp_okay, 1'b1);
    add_entry(op_read, 32'h0000_0044, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    add_entry(op_write, 32'h0000_0408, 32'hDEAD_BEEF, 4'hF, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_0008, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_01FC, 32'h1357_9BDF, 4'hF, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_01FC, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    // Privileged, fill the upper half
    add_entry(op_cfg, 32'h0, '0, 4'h0, 3'b001, resp_okay, 1'b0);
    add_entry(op_cfg, 32'h1, '0, 4'h0, 3'b001, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_0280, 32'h1122_3344, 4'hF, prot_reset, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_03FC, 32'h5566_7788, 4'hF, prot_reset, resp_okay, 1'b1);
    add_entry(op_read, 32'h0000_0280, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_03FC, 32'h0000_AA00, 4'h2, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_03FC, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    // Unprivileged again, the upper half refuses both directions
    add_entry(op_cfg, 32'h0, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_cfg, 32'h1, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_0280, 32'hFFFF_FFFF, 4'hF, prot_reset, resp_slverr, 1'b0);
    add_entry(op_write, 32'h0000_03FC, 32'h1212_1212, 4'h3, prot_reset, resp_slverr, 1'b1);
    add_entry(op_read, 32'h0000_0280, '0, 4'h0, prot_reset, resp_slverr, 1'b0);
    add_entry(op_read, 32'h0000_03FC, '0, 4'h0, prot_reset, resp_slverr, 1'b1);
    add_entry(op_read, 32'h0000_0010, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    // Privileged reads show the refused writes left the memory alone
    add_entry(op_cfg, 32'h1, '0, 4'h0, 3'b011, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_0280, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_03FC, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    add_entry(op_cfg, 32'h0, '0, 4'h0, 3'b001, resp_okay, 1'b0);
    add_entry(op_write, 32'h0000_0200, 32'hC0FF_EE00, 4'hF, prot_reset, resp_okay, 1'b0);
    add_entry(op_read, 32'h0000_0200, '0, 4'h0, prot_reset, resp_okay, 1'b0);
    // 0x600 wraps onto 0x200
    add_entry(op_write, 32'h0000_0600, 32'h0000_00AB, 4'h1, prot_reset, resp_okay, 1'b1);
    add_entry(op_read, 32'h0000_0200, '0, 4'h0, prot_reset, resp_okay, 1'b1);
    limit = 20 * tests.size() + 200;

    arst_n = 1'b0;
    cfg_we = 1'b0;
    cfg_addr = cfg_reg_aw_prot;
    cfg_wdata = prot_reset;
    lite_aw = '0;
    lite_w = '0;
    lite_ar = '0;
    lite_aw_valid = 1'b0;
    lite_w_valid = 1'b0;
    lite_ar_valid = 1'b0;
    lite_b_ready = 1'b0;
    lite_r_ready = 1'b0;
    aw_prot_now = prot_reset;
    ar_prot_now = prot_reset;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // Both registers come out of reset unprivileged
    @(posedge clk);
    #1;
    check_prot("config register 0 after reset", cfg_rdata, prot_reset);
    cfg_addr = cfg_reg_ar_prot;
    @(posedge clk);
    #1;
    check_prot("config register 1 after reset", cfg_rdata, prot_reset);

    foreach (tests[i]) begin
      e = tests[i];
      case (e.kind)
        op_cfg: write_cfg(e.addr[0], e.prot);
        op_write: begin
          lite_write_txn(e.addr, e.data, e.strb, e.stall, resp);
          writes_sent++;
          check_resp($sformatf("write 0x%08h", e.addr), resp, e.exp);
          if (access_allowed(e.addr, aw_prot_now)) begin
            model[word_index(e.addr)] = merge_strb(model[word_index(e.addr)], e.data, e.strb);
          end
        end
        default: begin
          lite_read_txn(e.addr, e.stall, rdata, resp);
          reads_sent++;
          check_resp($sformatf("read 0x%08h", e.addr), resp, e.exp);
          // A refused read returns zero data
          if (access_allowed(e.addr, ar_prot_now)) begin
            check_data($sformatf("read 0x%08h data", e.addr), rdata, model[word_index(e.addr)]);
          end else begin
            check_data($sformatf("refused read 0x%08h data", e.addr), rdata, '0);
          end
        end
      endcase
    end

    checks++;
    if (b_seen != writes_sent || r_seen != reads_sent) begin
      errors++;
      $display("Fail at %0t: %0d write and %0d read responses for %0d writes and %0d reads",
               $time, b_seen, r_seen, writes_sent, reads_sent);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hdl/axi_chan_pkg.sv
hdl/bridge_cfg_pkg.sv
hdl/spill_reg.sv
hdl/bridge_cfg_regs.sv
hdl/axi_lite_to_axi.sv
hdl/axi_sram_slave.sv
hdl/lite_bridge_top.sv
bench/tb_lite_bridge.sv

// File: Makefile
# Verilator build and run of the Lite bridge testbench
TOP := tb_lite_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing -f all.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module lite_bridge_top

clean:
	rm -rf obj_dir
